// ==== trace_encoder.f ====
trdb_cfg_pkg.sv
trdb_packet_pkg.sv
trdb_inst_if.sv
trdb_inst_pipe.sv
trdb_branch_map.sv
trdb_resync_timer.sv
trdb_encoder_fsm.sv
trdb_packet_emitter.sv
trace_encoder.sv
tb_trace_encoder.sv

// ==== tb_trace_encoder.sv ====
/* trace encoder testbench: instruction stream builder, reference model,
   packet comparison and cycle watchdog */
`timescale 1ns/1ps
`default_nettype none

module tb_trace_encoder import trdb_cfg_pkg::*, trdb_packet_pkg::*; ();

    localparam int MAX_INST = 128;
    localparam logic [6:0] OP_PLAIN  = 7'h13;
    localparam logic [6:0] OP_BRANCH = 7'h63;
    localparam logic [6:0] OP_JALR   = 7'h67;

    logic         clk = 1'b0;
    logic         rst_n;
    logic         inst_valid;
    logic         trace_enable;
    logic         exception;
    logic         interrupt;
    cause_t       cause;
    priv_t        priv;
    inst_t        inst_data;
    addr_t        iaddr;
    logic         pkt_valid;
    trdb_format_e pkt_format;
    plen_t        pkt_length;
    payload_t     pkt_payload;

    // stored stream, one entry per retired instruction
    logic   qual_a  [MAX_INST];
    logic   exc_a   [MAX_INST];
    logic   intr_a  [MAX_INST];
    cause_t cause_a [MAX_INST];
    priv_t  priv_a  [MAX_INST];
    inst_t  inst_a  [MAX_INST];
    addr_t  addr_a  [MAX_INST];
    int     gap_a   [MAX_INST];
    int     n_inst    = 0;
    int     gap_total = 0;
    integer seed      = 32'h5d92;
    // builder state standing in for the hart's pc and csrs
    logic   cur_en;
    priv_t  cur_priv;
    cause_t cur_cause;
    logic   cur_intr;
    addr_t  pc;

    logic [1:0] exp_format_q [$];
    plen_t      exp_length_q [$];
    payload_t   exp_payload_q [$];
    int errors      = 0;
    int checked     = 0;
    int cycles      = 0;
    int cycle_limit = 100000;

    always #4 clk = ~clk;

    trace_encoder dut0 (
        .clk_i            (clk),
        .rst_ni           (rst_n),
        .inst_valid_i     (inst_valid),
        .trace_enable_i   (trace_enable),
        .exception_i      (exception),
        .interrupt_i      (interrupt),
        .cause_i          (cause),
        .priv_i           (priv),
        .inst_data_i      (inst_data),
        .iaddr_i          (iaddr),
        .packet_valid_o   (pkt_valid),
        .packet_format_o  (pkt_format),
        .packet_length_o  (pkt_length),
        .packet_payload_o (pkt_payload)
    );

    task automatic append_inst(input logic [6:0] opcode, input logic taken, input logic exc);
        logic [31:0] r;
        r = $random(seed);
        qual_a[n_inst]  = cur_en;
        exc_a[n_inst]   = exc;
        intr_a[n_inst]  = cur_intr;
        cause_a[n_inst] = cur_cause;
        priv_a[n_inst]  = cur_priv;
        inst_a[n_inst]  = {r[31:7], opcode};
        addr_a[n_inst]  = pc;
        gap_a[n_inst]   = $unsigned($random(seed)) % 3;
        gap_total += gap_a[n_inst];
        // trap goes to a handler in machine mode
        if (exc) begin
            pc       = 32'h0000_0100 + (addr_t'(n_inst) << 4);
            cur_priv = 2'd3;
        end else if (opcode == OP_JALR) begin
            pc = 32'h0002_0000 + (addr_t'(n_inst) << 6);
        end else if (opcode == OP_BRANCH && taken) begin
            pc = pc + 32'h40;
        end else begin
            pc = pc + 32'd4;
        end
        n_inst++;
    endtask

    task automatic plain_run(input int count);
        for (int i = 0; i < count; i++) append_inst(OP_PLAIN, 1'b0, 1'b0);
    endtask

    task automatic branch_run(input int count);
        logic [31:0] r;
        for (int i = 0; i < count; i++) begin
            r = $random(seed);
            append_inst(OP_BRANCH, r[0], 1'b0);
        end
    endtask

    // walks the stream with j-1 and j+1 known for instruction j
    function automatic void predict_packets();
        logic       tracing, tracing_d, is_branch, nt, lc_exc, lc_jalr, push, emit, with_addr;
        logic [1:0] fmt, sub;
        int         count, count_d, timer;
        bmap_t      map, map_d;
        plen_t      len;
        payload_t   pl;
        tracing = 1'b0;
        count   = 0;
        timer   = 0;
        map     = '0;
        for (int j = 0; j < n_inst - 2; j++) begin
            is_branch = (inst_a[j][6:0] == 7'h63);
            nt        = (addr_a[j+1] == addr_a[j] + 32'd4);
            lc_exc    = (j > 0) && exc_a[j-1];
            lc_jalr   = (j > 0) && (inst_a[j-1][6:0] == 7'h67);
            push      = qual_a[j] && is_branch;
            map_d     = map;
            count_d   = count;
            if (push) begin
                map_d[count] = nt;
                count_d      = count + 1;
            end
            emit      = 1'b0;
            with_addr = 1'b0;
            fmt       = 2'd3;
            sub       = 2'd0;
            tracing_d = tracing;
            if (!tracing) begin
                if (qual_a[j]) begin
                    emit      = 1'b1;
                    tracing_d = 1'b1;
                end
            end else if (!qual_a[j]) begin
                tracing_d = 1'b0;
            end else if (lc_exc) begin
                emit = 1'b1;
                sub  = 2'd1;
            end else if (lc_jalr) begin
                emit      = 1'b1;
                fmt       = (count_d != 0) ? 2'd1 : 2'd2;
                with_addr = (count_d != 0);
            end else if (timer == 16) begin
                emit = 1'b1;
            end else if (count_d == 31) begin
                emit = 1'b1;
                fmt  = 2'd1;
            end
            if (emit) begin
                pl      = '0;
                pl[1:0] = fmt;
                len     = 4'd5;
                if (fmt == 2'd3) begin
                    pl[3:2]  = sub;
                    pl[5:4]  = priv_a[j];
                    // zero only for a taken branch
                    pl[6]    = !(is_branch && !nt);
                    pl[38:7] = addr_a[j];
                    if (sub == 2'd1) begin
                        pl[44:39] = cause_a[j];
                        pl[45]    = intr_a[j];
                        len       = 4'd6;
                    end
                end else if (fmt == 2'd2) begin
                    pl[33:2] = addr_a[j];
                end else begin
                    pl[6:2]  = count_d[4:0];
                    pl[37:7] = map_d;
                    if (with_addr) begin
                        pl[69:38] = addr_a[j];
                        len       = 4'd9;
                    end
                end
                exp_format_q.push_back(fmt);
                exp_length_q.push_back(len);
                exp_payload_q.push_back(pl);
            end
            if (emit || (tracing && !qual_a[j])) timer = 0;
            else if (tracing && timer < 16) timer++;
            map     = (emit || !qual_a[j]) ? '0 : map_d;
            count   = (emit || !qual_a[j]) ? 0 : count_d;
            tracing = tracing_d;
        end
    endfunction

    task automatic check_value(input string name, input logic [71:0] expected,
                               input logic [71:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t ns %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    // registered outputs are settled at the falling edge
    always @(negedge clk) begin
        if (rst_n && pkt_valid) begin
            checked++;
            if (exp_format_q.size() == 0) begin
                errors++;
                $display("packet at %0t ns arrived when none was expected", $time);
            end else begin
                check_value("packet_format_o", exp_format_q.pop_front(), pkt_format);
                check_value("packet_length_o", exp_length_q.pop_front(), pkt_length);
                check_value("packet_payload_o", exp_payload_q.pop_front(), pkt_payload);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d expected packets never arrived",
                     cycles, exp_format_q.size());
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        inst_valid   = 1'b0;
        trace_enable = 1'b0;
        exception    = 1'b0;
        interrupt    = 1'b0;
        cause        = '0;
        priv         = '0;
        inst_data    = '0;
        iaddr        = '0;
        rst_n        = 1'b0;
        cur_en       = 1'b0;
        cur_priv     = 2'd0;
        cur_cause    = '0;
        cur_intr     = 1'b0;
        pc           = 32'h0000_1000;

        plain_run(3);
        // first qualified instruction is a taken branch
        cur_en = 1'b1;
        append_inst(OP_BRANCH, 1'b1, 1'b0);
        plain_run(2);
        branch_run(3);
        append_inst(OP_JALR, 1'b0, 1'b0);
        plain_run(2);
        append_inst(OP_JALR, 1'b0, 1'b0);
        plain_run(2);
        // resync expires before the map can reach 31
        branch_run(31);
        plain_run(2);
        cur_cause = 6'd2;
        cur_intr  = 1'b0;
        append_inst(OP_PLAIN, 1'b0, 1'b1);
        plain_run(3);
        // trap on a jalr outranks the jump
        branch_run(2);
        cur_cause = 6'd7;
        cur_intr  = 1'b1;
        append_inst(OP_JALR, 1'b0, 1'b1);
        plain_run(3);
        plain_run(18);
        // branches still pending when the trace stops
        branch_run(2);
        cur_en = 1'b0;
        branch_run(4);
        plain_run(3);
        cur_en = 1'b1;
        plain_run(1);
        branch_run(2);
        append_inst(OP_JALR, 1'b0, 1'b0);
        plain_run(4);

        predict_packets();
        cycle_limit = 10 * (n_inst + gap_total);

        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        for (int k = 0; k < n_inst; k++) begin
            inst_valid   = 1'b1;
            trace_enable = qual_a[k];
            exception    = exc_a[k];
            interrupt    = intr_a[k];
            cause        = cause_a[k];
            priv         = priv_a[k];
            inst_data    = inst_a[k];
            iaddr        = addr_a[k];
            @(negedge clk);
            inst_valid = 1'b0;
            repeat (gap_a[k]) @(negedge clk);
        end
        // last packet lands one cycle after the final accept
        while (exp_format_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);

        $display("packets checked: %0d, errors: %0d", checked, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== trace_encoder.sv ====
/* trace encoder top: instruction window, branch map, resync timer,
   decision FSM and packet emitter */
`timescale 1ns/1ps
`default_nettype none

module trace_encoder
    import trdb_cfg_pkg::*;
    import trdb_packet_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         inst_valid_i,
    input  logic         trace_enable_i,
    input  logic         exception_i,
    input  logic         interrupt_i,
    input  cause_t       cause_i,
    input  priv_t        priv_i,
    input  inst_t        inst_data_i,
    input  addr_t        iaddr_i,
    output logic         packet_valid_o,
    output trdb_format_e packet_format_o,
    output plen_t        packet_length_o,
    output payload_t     packet_payload_o
);

    // fsm control
    logic                 push, map_clear;
    logic                 timer_count, timer_clear, expired;
    logic                 emit, with_addr;
    trdb_format_e         format;
    trdb_sync_subformat_e sync_sub;
    // branch map state including current push
    bmap_t                map_next;
    bcount_t              count_next;

    trdb_inst_if inst_if0 ();

    trdb_inst_pipe inst_pipe0 (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .inst_valid_i   (inst_valid_i),
        .trace_enable_i (trace_enable_i),
        .exception_i    (exception_i),
        .interrupt_i    (interrupt_i),
        .cause_i        (cause_i),
        .priv_i         (priv_i),
        .inst_data_i    (inst_data_i),
        .iaddr_i        (iaddr_i),
        .inst_o         (inst_if0)
    );

    trdb_branch_map branch_map0 (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .push_i       (push),
        .not_taken_i  (inst_if0.not_taken),
        .clear_i      (map_clear),
        .map_next_o   (map_next),
        .count_next_o (count_next)
    );

    trdb_resync_timer resync_timer0 (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .count_i   (timer_count),
        .clear_i   (timer_clear),
        .expired_o (expired)
    );

    trdb_encoder_fsm encoder_fsm0 (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .inst_i        (inst_if0),
        .count_next_i  (count_next),
        .expired_i     (expired),
        .push_o        (push),
        .map_clear_o   (map_clear),
        .timer_count_o (timer_count),
        .timer_clear_o (timer_clear),
        .emit_o        (emit),
        .with_addr_o   (with_addr),
        .format_o      (format),
        .sync_sub_o    (sync_sub)
    );

    trdb_packet_emitter packet_emitter0 (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .inst_i           (inst_if0),
        .emit_i           (emit),
        .with_addr_i      (with_addr),
        .format_i         (format),
        .sync_sub_i       (sync_sub),
        .map_i            (map_next),
        .count_i          (count_next),
        .packet_valid_o   (packet_valid_o),
        .packet_format_o  (packet_format_o),
        .packet_length_o  (packet_length_o),
        .packet_payload_o (packet_payload_o)
    );

endmodule

`default_nettype wire

// ==== trdb_packet_emitter.sv ====
/* packet payload packing and length selection, registered outputs */
`timescale 1ns/1ps
`default_nettype none

module trdb_packet_emitter
    import trdb_cfg_pkg::*;
    import trdb_packet_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_ni,
    trdb_inst_if.sink            inst_i,
    input  logic                 emit_i,
    input  logic                 with_addr_i,
    input  trdb_format_e         format_i,
    input  trdb_sync_subformat_e sync_sub_i,
    input  bmap_t                map_i,
    input  bcount_t              count_i,
    output logic                 packet_valid_o,
    output trdb_format_e         packet_format_o,
    output plen_t                packet_length_o,
    output payload_t             packet_payload_o
);

    payload_t payload_d;
    plen_t    length_d;
    logic     branch_bit;

    // cleared only for a taken branch
    assign branch_bit = ~(inst_i.branch & ~inst_i.not_taken);

    always_comb begin
        payload_d = '0;
        length_d  = LEN_SYNC_START;
        payload_d[P_FORMAT_LSB +: 2] = format_i;
        case (format_i)
            F_SYNC: begin
                payload_d[P_SUB_LSB +: 2]         = sync_sub_i;
                payload_d[P_PRIV_LSB +: PRIV_LEN] = inst_i.priv;
                payload_d[P_BRANCH_BIT]           = branch_bit;
                payload_d[P_SYNC_ADDR_LSB +: XLEN] = inst_i.iaddr;
                // trap variant appends the cause
                if (sync_sub_i == SF_TRAP) begin
                    payload_d[P_CAUSE_LSB +: CAUSE_LEN] = inst_i.cause;
                    payload_d[P_INTR_BIT]               = inst_i.interrupt;
                    length_d                            = LEN_SYNC_TRAP;
                end
            end
            F_ADDR_ONLY: begin
                payload_d[P_ADDR_LSB +: XLEN] = inst_i.iaddr;
                length_d                      = LEN_ADDR;
            end
            F_BRANCH_FULL: begin
                payload_d[P_BCOUNT_LSB +: BRANCH_COUNT_LEN] = count_i;
                payload_d[P_BMAP_LSB +: BRANCH_MAP_LEN]     = map_i;
                if (with_addr_i) begin
                    payload_d[P_BMAP_ADDR_LSB +: XLEN] = inst_i.iaddr;
                    length_d                           = LEN_BMAP_ADDR;
                end else begin
                    length_d = LEN_BMAP_FULL;
                end
            end
            default: ;
        endcase
    end

    // one-cycle valid, fields hold until the next packet
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            packet_valid_o   <= 1'b0;
            packet_format_o  <= trdb_format_e'(2'd0);
            packet_length_o  <= '0;
            packet_payload_o <= '0;
        end else begin
            packet_valid_o <= emit_i;
            if (emit_i) begin
                packet_format_o  <= format_i;
                packet_length_o  <= length_d;
                packet_payload_o <= payload_d;
            end
        end
    end

endmodule

`default_nettype wire

// ==== trdb_encoder_fsm.sv ====
/* tracing state machine, packet priority decision and
   control of the branch map and resync timer */
`timescale 1ns/1ps
`default_nettype none

module trdb_encoder_fsm
    import trdb_cfg_pkg::*;
    import trdb_packet_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_ni,
    trdb_inst_if.sink            inst_i,
    input  bcount_t              count_next_i,
    input  logic                 expired_i,
    output logic                 push_o,
    output logic                 map_clear_o,
    output logic                 timer_count_o,
    output logic                 timer_clear_o,
    output logic                 emit_o,
    output logic                 with_addr_o,
    output trdb_format_e         format_o,
    output trdb_sync_subformat_e sync_sub_o
);

    trace_state_e state_q, state_d;
    logic         tracing;
    logic         map_full;

    assign tracing  = (state_q == TRACING);
    assign map_full = (count_next_i == bcount_t'(BRANCH_MAP_LEN));

    // priority decision, only on an evaluated instruction
    always_comb begin
        state_d     = state_q;
        emit_o      = 1'b0;
        with_addr_o = 1'b0;
        format_o    = F_SYNC;
        sync_sub_o  = SF_START;
        if (inst_i.eval) begin
            if (!tracing) begin
                // first qualified instruction opens the trace
                if (inst_i.qualified) begin
                    emit_o  = 1'b1;
                    state_d = TRACING;
                end
            end else if (!inst_i.qualified) begin
                state_d = IDLE;
            end else if (inst_i.lc_exception) begin
                emit_o     = 1'b1;
                sync_sub_o = SF_TRAP;
            end else if (inst_i.lc_updiscon) begin
                emit_o = 1'b1;
                // pending branches ride along with the address
                if (count_next_i != '0) begin
                    format_o    = F_BRANCH_FULL;
                    with_addr_o = 1'b1;
                end else begin
                    format_o = F_ADDR_ONLY;
                end
            end else if (expired_i) begin
                emit_o = 1'b1;
            end else if (map_full) begin
                emit_o   = 1'b1;
                format_o = F_BRANCH_FULL;
            end
        end
    end

    // only qualified branches fill the map
    assign push_o      = inst_i.eval & inst_i.qualified & inst_i.branch;
    assign map_clear_o = emit_o | (inst_i.eval & ~inst_i.qualified);

    // timer tracks quiet instructions inside a trace
    assign timer_count_o = inst_i.eval & tracing & inst_i.qualified & ~emit_o;
    assign timer_clear_o = emit_o | (inst_i.eval & tracing & ~inst_i.qualified);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

`default_nettype wire

// ==== trdb_resync_timer.sv ====
/* count of instructions evaluated since the last packet */
`timescale 1ns/1ps
`default_nettype none

module trdb_resync_timer import trdb_cfg_pkg::*; (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic count_i,
    input  logic clear_i,
    output logic expired_o
);

    logic [RESYNC_CNT_LEN-1:0] count_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            count_q <= '0;
        end else if (clear_i) begin
            count_q <= '0;
        end else if (count_i && !expired_o) begin
            // holds at the limit until a packet goes out
            count_q <= count_q + 1'b1;
        end
    end

    assign expired_o = (count_q == RESYNC_CNT_LEN'(RESYNC_MAX));

endmodule

`default_nettype wire

// ==== trdb_branch_map.sv ====
/* conditional branch outcome map and its count */
`timescale 1ns/1ps
`default_nettype none

module trdb_branch_map import trdb_cfg_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_ni,
    input  logic    push_i,
    input  logic    not_taken_i,
    input  logic    clear_i,
    output bmap_t   map_next_o,
    output bcount_t count_next_o
);

    bmap_t   map_q;
    bcount_t count_q;

    // current push already folded in
    always_comb begin
        map_next_o   = map_q;
        count_next_o = count_q;
        if (push_i) begin
            // bit i is branch i, set when not taken
            map_next_o[count_q] = not_taken_i;
            count_next_o        = count_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            map_q   <= '0;
            count_q <= '0;
        end else if (clear_i) begin
            // the emitted packet took the outcomes
            map_q   <= '0;
            count_q <= '0;
        end else begin
            map_q   <= map_next_o;
            count_q <= count_next_o;
        end
    end

endmodule

`default_nettype wire

// ==== trdb_inst_pipe.sv ====
/* next/this/last instruction window, opcode decode of the next
   stage and not-taken detection from consecutive addresses */
`timescale 1ns/1ps
`default_nettype none

module trdb_inst_pipe import trdb_cfg_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              inst_valid_i,
    input  logic              trace_enable_i,
    input  logic              exception_i,
    input  logic              interrupt_i,
    input  cause_t            cause_i,
    input  priv_t             priv_i,
    input  inst_t             inst_data_i,
    input  addr_t             iaddr_i,
    trdb_inst_if.source       inst_o
);

    // next stage
    logic   next_valid_q, next_qual_q, next_exc_q, next_intr_q;
    cause_t next_cause_q;
    priv_t  next_priv_q;
    inst_t  next_inst_q;
    addr_t  next_iaddr_q;
    logic   next_branch, next_jalr;
    // this stage
    logic   this_valid_q, this_qual_q, this_exc_q, this_intr_q;
    logic   this_branch_q, this_jalr_q;
    cause_t this_cause_q;
    priv_t  this_priv_q;
    addr_t  this_iaddr_q;
    // last stage, only flags survive
    logic   last_valid_q, last_exc_q, last_jalr_q;

    // decode on the instruction word before it moves on
    assign next_branch = (next_inst_q[6:0] == OPCODE_BRANCH);
    assign next_jalr   = (next_inst_q[6:0] == OPCODE_JALR);

    // control flags, shift only on accept
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            next_valid_q  <= 1'b0;
            next_qual_q   <= 1'b0;
            next_exc_q    <= 1'b0;
            this_valid_q  <= 1'b0;
            this_qual_q   <= 1'b0;
            this_exc_q    <= 1'b0;
            this_branch_q <= 1'b0;
            this_jalr_q   <= 1'b0;
            last_valid_q  <= 1'b0;
            last_exc_q    <= 1'b0;
            last_jalr_q   <= 1'b0;
        end else if (inst_valid_i) begin
            next_valid_q  <= 1'b1;
            next_qual_q   <= trace_enable_i;
            next_exc_q    <= exception_i;
            this_valid_q  <= next_valid_q;
            this_qual_q   <= next_qual_q;
            this_exc_q    <= next_exc_q;
            this_branch_q <= next_valid_q & next_branch;
            this_jalr_q   <= next_valid_q & next_jalr;
            last_valid_q  <= this_valid_q;
            last_exc_q    <= this_exc_q;
            last_jalr_q   <= this_jalr_q;
        end
    end

    // instruction fields
    always_ff @(posedge clk_i) begin
        if (inst_valid_i) begin
            next_intr_q  <= interrupt_i;
            next_cause_q <= cause_i;
            next_priv_q  <= priv_i;
            next_inst_q  <= inst_data_i;
            next_iaddr_q <= iaddr_i;
            this_intr_q  <= next_intr_q;
            this_cause_q <= next_cause_q;
            this_priv_q  <= next_priv_q;
            this_iaddr_q <= next_iaddr_q;
        end
    end

    // "this" is judged when its second successor arrives
    assign inst_o.eval      = inst_valid_i & this_valid_q;
    assign inst_o.qualified = this_qual_q;
    assign inst_o.iaddr     = this_iaddr_q;
    assign inst_o.priv      = this_priv_q;
    assign inst_o.cause     = this_cause_q;
    assign inst_o.interrupt = this_intr_q;
    assign inst_o.branch    = this_branch_q;
    // sequential successor means the branch fell through
    assign inst_o.not_taken = (next_iaddr_q == this_iaddr_q + addr_t'(4));
    assign inst_o.lc_exception = last_valid_q & last_exc_q;
    assign inst_o.lc_updiscon  = last_valid_q & last_jalr_q;

endmodule

`default_nettype wire

// ==== trdb_inst_if.sv ====
/* view of the instruction under evaluation, with last-cycle flags */
`timescale 1ns/1ps
`default_nettype none

interface trdb_inst_if import trdb_cfg_pkg::*; ();

    // strobe for the "this" stage
    logic   eval;
    logic   qualified;
    // fields of the "this" instruction
    addr_t  iaddr;
    priv_t  priv;
    cause_t cause;
    logic   interrupt;
    logic   branch;
    logic   not_taken;
    // about the "last" instruction
    logic   lc_exception;
    logic   lc_updiscon;

    modport source (
        output eval, qualified, iaddr, priv, cause, interrupt,
        output branch, not_taken, lc_exception, lc_updiscon
    );

    modport sink (
        input eval, qualified, iaddr, priv, cause, interrupt,
        input branch, not_taken, lc_exception, lc_updiscon
    );

endinterface

`default_nettype wire

// ==== trdb_packet_pkg.sv ====
/* packet formats and sync subformats, payload field offsets,
   packet byte lengths, payload types and the tracing states */
`default_nettype none

package trdb_packet_pkg;

    localparam int PAYLOAD_LEN = 72;
    localparam int P_LEN       = 4;

    typedef logic [PAYLOAD_LEN-1:0] payload_t;
    typedef logic [P_LEN-1:0]       plen_t;

    typedef enum logic [1:0] {
        F_BRANCH_FULL = 2'd1,
        F_ADDR_ONLY   = 2'd2,
        F_SYNC        = 2'd3
    } trdb_format_e;

    typedef enum logic [1:0] {
        SF_START = 2'd0,
        SF_TRAP  = 2'd1
    } trdb_sync_subformat_e;

    typedef enum logic {
        IDLE,
        TRACING
    } trace_state_e;

    // common to all formats
    localparam int P_FORMAT_LSB = 0;
    // format 3
    localparam int P_SUB_LSB       = 2;
    localparam int P_PRIV_LSB      = 4;
    localparam int P_BRANCH_BIT    = 6;
    localparam int P_SYNC_ADDR_LSB = 7;
    localparam int P_CAUSE_LSB     = 39;
    localparam int P_INTR_BIT      = 45;
    // format 2
    localparam int P_ADDR_LSB = 2;
    // format 1
    localparam int P_BCOUNT_LSB    = 2;
    localparam int P_BMAP_LSB      = 7;
    localparam int P_BMAP_ADDR_LSB = 38;

    // packet lengths in bytes
    localparam plen_t LEN_SYNC_START = 4'd5;
    localparam plen_t LEN_SYNC_TRAP  = 4'd6;
    localparam plen_t LEN_ADDR       = 4'd5;
    localparam plen_t LEN_BMAP_ADDR  = 4'd9;
    localparam plen_t LEN_BMAP_FULL  = 4'd5;

endpackage

`default_nettype wire

// ==== trdb_cfg_pkg.sv ====
/* encoder core configuration: data widths, major opcodes,
   resync limit and the vector types built on them */
`default_nettype none

package trdb_cfg_pkg;

    // core data widths
    localparam int XLEN      = 32;
    localparam int INST_LEN  = 32;
    localparam int CAUSE_LEN = 6;
    localparam int PRIV_LEN  = 2;

    // branch map holds up to 31 outcomes
    localparam int BRANCH_MAP_LEN   = 31;
    localparam int BRANCH_COUNT_LEN = 5;

    // instructions without a packet before a forced sync
    localparam int RESYNC_MAX     = 16;
    localparam int RESYNC_CNT_LEN = $clog2(RESYNC_MAX + 1);

    // major opcodes, inst[6:0]
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
    localparam logic [6:0] OPCODE_JALR   = 7'b1100111;

    typedef logic [XLEN-1:0]             addr_t;
    typedef logic [INST_LEN-1:0]         inst_t;
    typedef logic [CAUSE_LEN-1:0]        cause_t;
    typedef logic [PRIV_LEN-1:0]         priv_t;
    typedef logic [BRANCH_MAP_LEN-1:0]   bmap_t;
    typedef logic [BRANCH_COUNT_LEN-1:0] bcount_t;

endpackage

`default_nettype wire
